// ==== Bender.yml ====
package:
  name: msix_tx_bridge

sources:
  - files:
      - hdl/msix_pkg.sv
      - hdl/msix_vector_fifo.sv
      - hdl/msix_tx_bridge.sv
      - hdl/msix_cfg_regs.sv
      - hdl/msix_tx_top.sv
  - target: test
    files:
      - tb/msix_tx_chk.sv
      - tb/msix_tx_tb.sv

// ==== flist.f ====
hdl/msix_pkg.sv
hdl/msix_vector_fifo.sv
hdl/msix_tx_bridge.sv
hdl/msix_cfg_regs.sv
hdl/msix_tx_top.sv
tb/msix_tx_chk.sv
tb/msix_tx_tb.sv

// ==== hdl/msix_cfg_regs.sv ====
// --------------------
// MSI-X bridge register block
// Wishbone classic slave with control and status counters
// --------------------
`default_nettype none

module msix_cfg_regs (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       wb_cyc,
    input  wire logic                       wb_stb,
    input  wire logic                       wb_we,
    input  wire logic [msix_pkg::WB_AW-1:0] wb_adr,
    input  wire logic [msix_pkg::WB_DW-1:0] wb_dat_i,
    input  wire logic [3:0]                 wb_sel,
    output logic      [msix_pkg::WB_DW-1:0] wb_dat_o,
    output logic                            wb_ack,
    input  wire logic                       beat_sent,
    input  wire logic                       vec_dropped,
    output logic                            tx_enable,
    output logic      [msix_pkg::PF_W-1:0]  pf_num,
    output logic      [msix_pkg::VF_W-1:0]  vf_num,
    output logic                            vf_active
);

    logic [msix_pkg::CTRL_W-1:0] ctrl;
    logic [msix_pkg::CNT_W-1:0]  sent_cnt;
    logic [msix_pkg::CNT_W-1:0]  drop_cnt;
    logic                        access;
    logic                        wr_access;
    logic                        clr_sent;
    logic                        clr_drop;

    // Every register is written as a whole word
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign wr_access = access && wb_we;
    assign clr_sent  = wr_access && (wb_adr == msix_pkg::ADDR_SENT);
    assign clr_drop  = wr_access && (wb_adr == msix_pkg::ADDR_DROP);

    assign tx_enable = ctrl[msix_pkg::CTRL_EN_BIT];
    assign vf_active = ctrl[msix_pkg::CTRL_VFA_BIT];
    assign pf_num    = ctrl[msix_pkg::CTRL_PF_OFS +: msix_pkg::PF_W];
    assign vf_num    = ctrl[msix_pkg::CTRL_VF_OFS +: msix_pkg::VF_W];

    // --------------------
    // Control register and ack
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_ack <= 1'b0;
            ctrl   <= '0;
        end
        else
        begin
            wb_ack <= access;
            if (wr_access && (wb_adr == msix_pkg::ADDR_CTRL))
            begin
                ctrl <= wb_dat_i[msix_pkg::CTRL_W-1:0];
            end
        end
    end

    // --------------------
    // Saturating status counters where a clear wins
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sent_cnt <= '0;
            drop_cnt <= '0;
        end
        else
        begin
            if (clr_sent)
                sent_cnt <= '0;
            else if (beat_sent && (sent_cnt != '1))
                sent_cnt <= sent_cnt + 1'b1;

            if (clr_drop)
                drop_cnt <= '0;
            else if (vec_dropped && (drop_cnt != '1))
                drop_cnt <= drop_cnt + 1'b1;
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            case (wb_adr)
                msix_pkg::ADDR_CTRL: wb_dat_o <= msix_pkg::WB_DW'(ctrl);
                msix_pkg::ADDR_SENT: wb_dat_o <= msix_pkg::WB_DW'(sent_cnt);
                msix_pkg::ADDR_DROP: wb_dat_o <= msix_pkg::WB_DW'(drop_cnt);
                default:             wb_dat_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/msix_pkg.sv ====
// --------------------
// MSI-X transmit bridge shared definitions
// Sizes, register map and interrupt header layout
// --------------------
`default_nettype none

package msix_pkg;

    // Vector queue
    localparam int VEC_W           = 16;
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_AW         = 4;
    localparam int ALMOST_FULL_LVL = 12;

    // Function identity
    localparam int PF_W = 3;
    localparam int VF_W = 11;

    // Stream and status widths
    localparam int TDATA_W = 64;
    localparam int CNT_W   = 16;

    // --------------------
    // Wishbone register map
    localparam int WB_AW = 2;
    localparam int WB_DW = 32;

    localparam logic [WB_AW-1:0] ADDR_CTRL = 2'd0;
    localparam logic [WB_AW-1:0] ADDR_SENT = 2'd1;
    localparam logic [WB_AW-1:0] ADDR_DROP = 2'd2;

    // CTRL fields, upper bits read as zero
    localparam int CTRL_W       = 16;
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_VFA_BIT = 1;
    localparam int CTRL_PF_OFS  = 2;
    localparam int CTRL_VF_OFS  = 5;

    // --------------------
    // Interrupt header layout, LSB first
    localparam int FMT_W       = 8;
    localparam int HDR_FMT_OFS = 0;
    localparam int HDR_PF_OFS  = 8;
    localparam int HDR_VF_OFS  = 11;
    localparam int HDR_VFA_OFS = 22;
    localparam int HDR_VEC_OFS = 32;

    typedef enum logic [FMT_W-1:0] {
        MEM_WR  = 8'h60,
        MSG     = 8'h34,
        DM_INTR = 8'h30
    } msix_fmt_e;

endpackage

`default_nettype wire

// ==== hdl/msix_tx_bridge.sv ====
// --------------------
// MSI-X transmit bridge
// Queues strobed vectors and sends one interrupt header beat each
// --------------------
`default_nettype none

module msix_tx_bridge (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         msix_strb,
    input  wire logic [msix_pkg::VEC_W-1:0]   msix_num,
    output logic                              msix_ready,
    output logic                              tx_valid,
    output logic                              tx_last,
    output logic      [msix_pkg::TDATA_W-1:0] tx_data,
    input  wire logic                         tx_ready,
    input  wire logic                         tx_enable,
    input  wire logic [msix_pkg::PF_W-1:0]    pf_num,
    input  wire logic [msix_pkg::VF_W-1:0]    vf_num,
    input  wire logic                         vf_active,
    output logic                              beat_sent,
    output logic                              vec_dropped
);

    logic                       fifo_wr_en;
    logic [msix_pkg::VEC_W-1:0] fifo_wr_data;
    logic                       fifo_rd_en;
    logic [msix_pkg::VEC_W-1:0] fifo_rd_data;
    logic                       fifo_empty;
    logic                       fifo_almost_full;

    // --------------------
    // Host side
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            fifo_wr_en <= 1'b0;
            msix_ready <= 1'b0;
        end
        else
        begin
            fifo_wr_en <= msix_strb;
            msix_ready <= !fifo_almost_full;
        end
    end

    // Vector payload follows the strobe register
    always_ff @(posedge clk)
    begin
        fifo_wr_data <= msix_num;
    end

    msix_vector_fifo i_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .almost_full (fifo_almost_full),
        .dropped     (vec_dropped)
    );

    // --------------------
    // Stream side
    assign tx_valid   = !fifo_empty && tx_enable;
    assign tx_last    = tx_valid;
    assign fifo_rd_en = tx_valid && tx_ready;
    assign beat_sent  = fifo_rd_en;

    // DM interrupt header, unused bits zero
    always_comb
    begin
        tx_data = '0;
        tx_data[msix_pkg::HDR_FMT_OFS +: msix_pkg::FMT_W] = msix_pkg::DM_INTR;
        tx_data[msix_pkg::HDR_PF_OFS +: msix_pkg::PF_W]   = pf_num;
        tx_data[msix_pkg::HDR_VF_OFS +: msix_pkg::VF_W]   = vf_num;
        tx_data[msix_pkg::HDR_VFA_OFS]                    = vf_active;
        tx_data[msix_pkg::HDR_VEC_OFS +: msix_pkg::VEC_W] = fifo_rd_data;
    end

endmodule

`default_nettype wire

// ==== hdl/msix_tx_top.sv ====
// --------------------
// MSI-X transmit subsystem top
// Register block beside the transmit bridge
// --------------------
`default_nettype none

module msix_tx_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    // Host side
    input  wire logic                         msix_strb,
    input  wire logic [msix_pkg::VEC_W-1:0]   msix_num,
    output logic                              msix_ready,
    // Stream source
    output logic                              tx_valid,
    output logic                              tx_last,
    output logic      [msix_pkg::TDATA_W-1:0] tx_data,
    input  wire logic                         tx_ready,
    // Wishbone slave
    input  wire logic                         wb_cyc,
    input  wire logic                         wb_stb,
    input  wire logic                         wb_we,
    input  wire logic [msix_pkg::WB_AW-1:0]   wb_adr,
    input  wire logic [msix_pkg::WB_DW-1:0]   wb_dat_i,
    input  wire logic [3:0]                   wb_sel,
    output logic      [msix_pkg::WB_DW-1:0]   wb_dat_o,
    output logic                              wb_ack
);

    logic                      tx_enable;
    logic [msix_pkg::PF_W-1:0] pf_num;
    logic [msix_pkg::VF_W-1:0] vf_num;
    logic                      vf_active;
    logic                      beat_sent;
    logic                      vec_dropped;

    msix_cfg_regs i_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_sel      (wb_sel),
        .wb_dat_o    (wb_dat_o),
        .wb_ack      (wb_ack),
        .beat_sent   (beat_sent),
        .vec_dropped (vec_dropped),
        .tx_enable   (tx_enable),
        .pf_num      (pf_num),
        .vf_num      (vf_num),
        .vf_active   (vf_active)
    );

    msix_tx_bridge i_bridge (
        .clk         (clk),
        .rst_n       (rst_n),
        .msix_strb   (msix_strb),
        .msix_num    (msix_num),
        .msix_ready  (msix_ready),
        .tx_valid    (tx_valid),
        .tx_last     (tx_last),
        .tx_data     (tx_data),
        .tx_ready    (tx_ready),
        .tx_enable   (tx_enable),
        .pf_num      (pf_num),
        .vf_num      (vf_num),
        .vf_active   (vf_active),
        .beat_sent   (beat_sent),
        .vec_dropped (vec_dropped)
    );

endmodule

`default_nettype wire

// ==== hdl/msix_vector_fifo.sv ====
// --------------------
// MSI-X vector FIFO
// Register-array queue with lookahead read and overflow drop
// --------------------
`default_nettype none

module msix_vector_fifo (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       wr_en,
    input  wire logic [msix_pkg::VEC_W-1:0] wr_data,
    input  wire logic                       rd_en,
    output logic      [msix_pkg::VEC_W-1:0] rd_data,
    output logic                            empty,
    output logic                            almost_full,
    output logic                            dropped
);

    logic [msix_pkg::VEC_W-1:0] mem [msix_pkg::FIFO_DEPTH];

    logic [msix_pkg::FIFO_AW-1:0] wr_ptr;
    logic [msix_pkg::FIFO_AW-1:0] rd_ptr;
    logic [msix_pkg::FIFO_AW:0]   count;
    logic                         full;
    logic                         do_wr;
    logic                         do_rd;

    assign full  = (count == (msix_pkg::FIFO_AW + 1)'(msix_pkg::FIFO_DEPTH));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign almost_full = (count >= (msix_pkg::FIFO_AW + 1)'(msix_pkg::ALMOST_FULL_LVL));

    // Head entry is always on the output
    assign rd_data = mem[rd_ptr];

    // --------------------
    // Storage
    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // --------------------
    // Pointers and level
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            empty   <= 1'b1;
            dropped <= 1'b0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (msix_pkg::FIFO_AW + 1)'(do_wr) - (msix_pkg::FIFO_AW + 1)'(do_rd);
            // Empty flag lags a write by one cycle
            empty   <= do_rd ? (count <= 1) : (count == 0);
            dropped <= wr_en && full;
        end
    end

endmodule

`default_nettype wire

// ==== tb/msix_tx_chk.sv ====
// --------------------
// MSI-X transmit protocol checker
// Stream hold, Wishbone ack and last flag assertions
// --------------------
`default_nettype none

module msix_tx_chk (
    input wire logic                         clk,
    input wire logic                         rst_n,
    input wire logic                         tx_valid,
    input wire logic                         tx_ready,
    input wire logic                         tx_last,
    input wire logic [msix_pkg::TDATA_W-1:0] tx_data,
    input wire logic                         tx_enable,
    input wire logic                         wb_ack
);

    int error_count = 0;

    // Stalled beat holds unless enable drops
    stream_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_valid && !tx_ready && tx_enable) |=>
        (!tx_enable || (tx_valid && $stable(tx_data))))
    else
    begin
        $error("stalled stream beat changed or was withdrawn");
        error_count++;
    end

    ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else
    begin
        $error("Wishbone acknowledge held longer than one cycle");
        error_count++;
    end

    last_match: assert property (@(posedge clk) disable iff (!rst_n) tx_last == tx_valid)
    else
    begin
        $error("tx_last differs from tx_valid");
        error_count++;
    end

endmodule

bind msix_tx_top msix_tx_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .tx_last   (tx_last),
    .tx_data   (tx_data),
    .tx_enable (tx_enable),
    .wb_ack    (wb_ack)
);

`default_nettype wire

// ==== tb/msix_tx_tb.sv ====
// --------------------
// MSI-X transmit subsystem testbench
// Table-driven Wishbone and vector stimulus with a stream monitor
// --------------------
`default_nettype none

module msix_tx_tb;

    typedef enum logic [2:0] {
        WB_WRITE,
        WB_READ_EXPECT,
        SEND_VECTORS,
        DRAIN_EXPECT,
        IDLE
    } step_op_e;

    // arg is a register address or a count
    typedef struct packed {
        step_op_e    op;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic                         clk;
    logic                         rst_n;
    logic                         msix_strb;
    logic [msix_pkg::VEC_W-1:0]   msix_num;
    logic                         msix_ready;
    logic                         tx_valid;
    logic                         tx_last;
    logic [msix_pkg::TDATA_W-1:0] tx_data;
    logic                         tx_ready;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [msix_pkg::WB_AW-1:0]   wb_adr;
    logic [msix_pkg::WB_DW-1:0]   wb_dat_i;
    logic [3:0]                   wb_sel;
    logic [msix_pkg::WB_DW-1:0]   wb_dat_o;
    logic                         wb_ack;

    logic [msix_pkg::VEC_W-1:0]   exp_q [$];
    logic [msix_pkg::TDATA_W-1:0] rx_q [$];
    logic [msix_pkg::WB_DW-1:0]   ctrl_shadow;
    logic                         ready_low_seen;
    logic [15:0]                  lfsr;

    step_t steps [22] = '{
        '{WB_READ_EXPECT, msix_pkg::ADDR_CTRL, 32'h0, 32'h0},
        '{WB_WRITE, msix_pkg::ADDR_CTRL, 32'hDEAD_BEEE, 32'h0},
        '{WB_READ_EXPECT, msix_pkg::ADDR_CTRL, 32'h0, 32'h0000_BEEE},
        // Enable under pf 5 and vf 0x2A5 with vf_active set
        '{WB_WRITE, msix_pkg::ADDR_CTRL, 32'h0000_54B7, 32'h0},
        '{SEND_VECTORS, 32'd8, 32'h0100, 32'h0},
        '{DRAIN_EXPECT, 32'd8, 32'h0, 32'h0},
        // Queue while disabled and release under pf 2 and vf 0x155
        '{WB_WRITE, msix_pkg::ADDR_CTRL, 32'h0000_54B6, 32'h0},
        '{SEND_VECTORS, 32'd6, 32'h0200, 32'h0},
        '{IDLE, 32'd40, 32'h0, 32'h0},
        '{WB_WRITE, msix_pkg::ADDR_CTRL, 32'h0000_2AA9, 32'h0},
        '{DRAIN_EXPECT, 32'd6, 32'h0, 32'h0},
        // Overflow
        '{WB_WRITE, msix_pkg::ADDR_CTRL, 32'h0000_2AA8, 32'h0},
        '{SEND_VECTORS, msix_pkg::FIFO_DEPTH + 4, 32'h0A00, 32'h0},
        '{IDLE, 32'd20, 32'h0, 32'h0},
        '{WB_WRITE, msix_pkg::ADDR_CTRL, 32'h0000_2AA9, 32'h0},
        '{DRAIN_EXPECT, msix_pkg::FIFO_DEPTH, 32'h0, 32'h1},
        '{WB_READ_EXPECT, msix_pkg::ADDR_DROP, 32'h0, 32'd4},
        '{WB_READ_EXPECT, msix_pkg::ADDR_SENT, 32'h0, 8 + 6 + msix_pkg::FIFO_DEPTH},
        '{WB_WRITE, msix_pkg::ADDR_SENT, 32'h0, 32'h0},
        '{WB_WRITE, msix_pkg::ADDR_DROP, 32'h0, 32'h0},
        '{WB_READ_EXPECT, msix_pkg::ADDR_SENT, 32'h0, 32'h0},
        '{WB_READ_EXPECT, msix_pkg::ADDR_DROP, 32'h0, 32'h0}
    };

    msix_tx_top i_dut (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_data(input string name, input logic [msix_pkg::TDATA_W-1:0] got,
                                input logic [msix_pkg::TDATA_W-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_word(input string name, input logic [msix_pkg::WB_DW-1:0] got,
                                input logic [msix_pkg::WB_DW-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Interrupt header for one vector under a CTRL word
    function automatic logic [msix_pkg::TDATA_W-1:0] expected_beat(
        input logic [msix_pkg::WB_DW-1:0] ctrl,
        input logic [msix_pkg::VEC_W-1:0] vec
    );
        logic [msix_pkg::TDATA_W-1:0] hdr;
        hdr = '0;
        hdr[msix_pkg::HDR_FMT_OFS +: msix_pkg::FMT_W] = msix_pkg::DM_INTR;
        hdr[msix_pkg::HDR_PF_OFS +: msix_pkg::PF_W] =
            ctrl[msix_pkg::CTRL_PF_OFS +: msix_pkg::PF_W];
        hdr[msix_pkg::HDR_VF_OFS +: msix_pkg::VF_W] =
            ctrl[msix_pkg::CTRL_VF_OFS +: msix_pkg::VF_W];
        hdr[msix_pkg::HDR_VFA_OFS] = ctrl[msix_pkg::CTRL_VFA_BIT];
        hdr[msix_pkg::HDR_VEC_OFS +: msix_pkg::VEC_W] = vec;
        return hdr;
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic wb_access(input logic we, input logic [msix_pkg::WB_AW-1:0] adr,
                             input logic [msix_pkg::WB_DW-1:0] dat,
                             output logic [msix_pkg::WB_DW-1:0] rdata);
        int waited;
        next_drive_slot();
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = dat;
        waited   = 0;
        @(negedge clk);
        while (!wb_ack)
        begin
            waited++;
            if (waited > 16)
                stop_with_failure("Wishbone access was never acknowledged");
            @(negedge clk);
        end
        rdata = wb_dat_o;
        next_drive_slot();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Strobes one vector per cycle and models the FIFO drop rule
    task automatic send_vectors(input int count, input logic [msix_pkg::VEC_W-1:0] base);
        logic [msix_pkg::VEC_W-1:0] vec;
        ready_low_seen = 1'b0;
        for (int k = 0; k < count; k++)
        begin
            vec = base + msix_pkg::VEC_W'(k);
            next_drive_slot();
            msix_strb = 1'b1;
            msix_num  = vec;
            if (exp_q.size() - rx_q.size() < msix_pkg::FIFO_DEPTH)
                exp_q.push_back(vec);
        end
        next_drive_slot();
        msix_strb = 1'b0;
    endtask

    task automatic drain_expect(input int count, input logic exp_ready_low);
        logic [msix_pkg::TDATA_W-1:0] beat;
        logic [msix_pkg::VEC_W-1:0]   vec;
        int                           waited;
        compare_bit("msix_ready_low_seen", ready_low_seen, exp_ready_low);
        for (int k = 0; k < count; k++)
        begin
            waited = 0;
            while (rx_q.size() == 0)
            begin
                waited++;
                if (waited > 200)
                    stop_with_failure("timed out waiting for a stream beat");
                @(posedge clk);
            end
            beat = rx_q.pop_front();
            vec  = exp_q.pop_front();
            compare_data("tx_data", beat, expected_beat(ctrl_shadow, vec));
        end
    endtask

    task automatic idle_check(input int cycles, input logic exp_valid);
        repeat (cycles)
        begin
            @(negedge clk);
            compare_bit("tx_valid", tx_valid, exp_valid);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Random back-pressure from one LFSR bit per cycle
    initial
    begin
        lfsr     = 16'd69;
        tx_ready = 1'b0;
        forever
        begin
            next_drive_slot();
            lfsr     = lfsr_step(lfsr);
            tx_ready = lfsr[0];
        end
    end

    // --------------------
    // Stream monitor
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (tx_valid && tx_ready)
                rx_q.push_back(tx_data);
            if (!msix_ready)
                ready_low_seen = 1'b1;
            if (i_dut.i_chk.error_count != 0)
                stop_with_failure("a protocol assertion in the bound checker failed");
        end
    end

    initial
    begin
        step_t                      st;
        logic [msix_pkg::WB_DW-1:0] rdata;
        int                         waited;
        rst_n          = 1'b0;
        msix_strb      = 1'b0;
        msix_num       = '0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_i       = '0;
        wb_sel         = 4'hF;
        ctrl_shadow    = '0;
        ready_low_seen = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        compare_bit("tx_valid", tx_valid, 1'b0);
        compare_bit("wb_ack", wb_ack, 1'b0);
        waited = 0;
        while (!msix_ready)
        begin
            waited++;
            if (waited > 10)
                stop_with_failure("msix_ready did not rise after reset");
            @(negedge clk);
        end

        // --------------------
        // Stimulus table
        foreach (steps[i])
        begin
            st = steps[i];
            case (st.op)
                WB_WRITE:
                begin
                    wb_access(1'b1, st.arg[msix_pkg::WB_AW-1:0], st.data, rdata);
                    if (st.arg[msix_pkg::WB_AW-1:0] == msix_pkg::ADDR_CTRL)
                        ctrl_shadow = st.data;
                end
                WB_READ_EXPECT:
                begin
                    wb_access(1'b0, st.arg[msix_pkg::WB_AW-1:0], '0, rdata);
                    compare_word("wb_dat_o", rdata, st.exp);
                end
                SEND_VECTORS: send_vectors(st.arg, st.data[msix_pkg::VEC_W-1:0]);
                DRAIN_EXPECT: drain_expect(st.arg, st.exp[0]);
                IDLE:         idle_check(st.arg, st.exp[0]);
                default:      stop_with_failure("unknown operation in the stimulus table");
            endcase
        end

        if (rx_q.size() != 0)
            stop_with_failure("stream delivered a beat with no queued vector");
        else if (i_dut.i_chk.error_count != 0)
            stop_with_failure("a protocol assertion in the bound checker failed");
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
